// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing
TOP        = mipsPipelineTb
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
PASS_MSG   = *** TEST PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q -F '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== verilog.f ====
+incdir+design
design/mipsPkg.sv
design/registerFile.sv
design/controlUnit.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/hazardUnit.sv
design/mipsPipeline.sv
testbench/mipsPipelineTb.sv

// ==== testbench/mipsPipelineTb.sv ====
`include "mips_settings.svh"

module mipsPipelineTb;
	import mipsPkg::*;

	localparam int  ClkPeriod = 40;
	localparam int  NumTests  = 5;
	localparam word DoneAddr  = 32'h0000_03FC;

	logic   iCLK;
	logic   iRST;
	word    instrAddr;
	word    instrData;
	dataBus dBus;
	word    dataRead;
	regIdx  regSelect;
	word    regValue;

	word  instrMem [256];
	word  dataMem [256];
	word  prog [$];
	word  stAddr [$];    // Stores seen on dBus
	word  stData [$];
	word  expAddr [$];
	word  expData [$];
	logic doneSeen;

	mipsPipeline i_mipsPipeline (.*);

	// Word-addressed models with load data only under the read strobe
	assign instrData = instrMem[instrAddr[9:2]];
	assign dataRead  = dBus.read ? dataMem[dBus.address[9:2]] : '0;

	always @(posedge iCLK) begin
		if (dBus.write === 1'b1) begin
			dataMem[dBus.address[9:2]] = dBus.writeData;
			if (dBus.address == DoneAddr) begin
				doneSeen = 1'b1;
			end else begin
				stAddr.push_back(dBus.address);
				stData.push_back(dBus.writeData);
			end
		end
	end

	initial begin
		iCLK = 1'b0;
		forever #(ClkPeriod / 2) iCLK = ~iCLK;
	end

	initial begin
		#(NumTests * 400 * ClkPeriod);
		$display("ERROR: timeout, a program never reached its done store");
		$display("*** TEST FAILED ***");
		$fatal(1, "watchdog expired");
	end

	function automatic word encR(input logic [5:0] fn, input regIdx rd, input regIdx rs,
			input regIdx rt);
		return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word encI(input logic [5:0] op, input regIdx rt, input regIdx rs,
			input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word encJ(input word addr);
		return {`OP_J, addr[27:2]};
	endfunction

	function automatic word signExt(input logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	function automatic word here();
		return word'(prog.size() * 4);
	endfunction

	task automatic checkEq(input word got, input word exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s, got %h, expected %h", $time, what, got, exp);
			$display("*** TEST FAILED ***");
			$fatal(1, "check failed");
		end
	endtask

	task automatic emit(input word instr);
		prog.push_back(instr);
	endtask

	task automatic expectStore(input word addr, input word data);
		expAddr.push_back(addr);
		expData.push_back(data);
	endtask

	task automatic newProgram();
		prog.delete();
		expAddr.delete();
		expData.delete();
	endtask

	// Done marker store followed by a self-jump
	task automatic finishProgram();
		emit(encI(`OP_SW, 5'd0, 5'd0, DoneAddr[15:0]));
		emit(encJ(here()));
	endtask

	task automatic holdReset();
		iRST = 1'b1;
		repeat (16) begin
			@(negedge iCLK);
			checkEq(word'(dBus.write), 0, "dBus write during reset");
			checkEq(word'(dBus.read), 0, "dBus read during reset");
			checkEq(instrAddr, `RESET_PC, "fetch address during reset");
		end
		iRST = 1'b0;
	endtask

	task automatic startRun();
		@(negedge iCLK);
		iRST = 1'b1;    // Old program stops before the ROM changes
		stAddr.delete();
		stData.delete();
		doneSeen = 1'b0;
		for (int i = 0; i < 256; i++) begin
			instrMem[i] = (i < prog.size()) ? prog[i] : '0;
		end
		holdReset();
	endtask

	task automatic checkStores();
		checkEq(word'(stAddr.size()), word'(expAddr.size()), "number of stores");
		foreach (expAddr[i]) begin
			checkEq(stAddr[i], expAddr[i], $sformatf("address of store %0d", i));
			checkEq(stData[i], expData[i], $sformatf("data of store %0d", i));
		end
	endtask

	task automatic runProgram();
		startRun();
		while (!doneSeen) @(negedge iCLK);
		checkStores();
	endtask

	task automatic checkReg(input regIdx idx, input word exp);
		@(negedge iCLK);
		regSelect = idx;
		@(negedge iCLK);
		checkEq(regValue, exp, $sformatf("debug read of r%0d", idx));
	endtask

	task automatic aluChainTest();
		word         v [13];
		word         a;
		word         b;
		logic [15:0] imm [4];
		a = $urandom();
		b = $urandom();
		for (int i = 0; i < 4; i++) begin
			imm[i] = 16'($urandom());
		end
		v[0]  = '0;
		v[1]  = a;
		v[2]  = b;
		v[3]  = a + b;
		v[4]  = v[3] - a;
		v[5]  = v[4] & v[3];
		v[6]  = v[5] | a;
		v[7]  = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		v[8]  = v[7] + signExt(imm[0]);
		v[9]  = v[8] & {16'h0000, imm[1]};
		v[10] = v[9] | {16'h0000, imm[2]};
		v[11] = {imm[3], 16'h0000};
		v[12] = '0;
		newProgram();
		emit(encI(`OP_LUI, 5'd1, 5'd0, a[31:16]));
		emit(encI(`OP_ORI, 5'd1, 5'd1, a[15:0]));
		emit(encI(`OP_LUI, 5'd2, 5'd0, b[31:16]));
		emit(encI(`OP_ORI, 5'd2, 5'd2, b[15:0]));
		emit(encR(`FN_ADDU, 5'd3, 5'd1, 5'd2));
		emit(encR(`FN_SUBU, 5'd4, 5'd3, 5'd1));
		emit(encR(`FN_AND, 5'd5, 5'd4, 5'd3));    // MEM and WB sources together
		emit(encR(`FN_OR, 5'd6, 5'd5, 5'd1));
		emit(encR(`FN_SLT, 5'd7, 5'd1, 5'd2));
		emit(encI(`OP_ADDIU, 5'd8, 5'd7, imm[0]));
		emit(encI(`OP_ANDI, 5'd9, 5'd8, imm[1]));
		emit(encI(`OP_ORI, 5'd10, 5'd9, imm[2]));
		emit(encI(`OP_LUI, 5'd11, 5'd0, imm[3]));
		emit(encI(`OP_ADDIU, 5'd0, 5'd1, 16'd5));    // Write to $zero is dropped
		emit(encR(`FN_ADDU, 5'd12, 5'd0, 5'd0));
		for (int k = 1; k <= 12; k++) begin
			emit(encI(`OP_SW, regIdx'(k), 5'd0, 16'(k * 4)));
			expectStore(word'(k * 4), v[k]);
		end
		finishProgram();
		runProgram();
		for (int k = 0; k <= 12; k++) begin
			checkReg(regIdx'(k), v[k]);
		end
	endtask

	task automatic loadUseTest();
		word         v;
		logic [15:0] k;
		v = $urandom();
		k = 16'($urandom());
		dataMem[16] = v;    // Address 0x40
		newProgram();
		emit(encI(`OP_ADDIU, 5'd2, 5'd0, k));
		emit(encI(`OP_LW, 5'd1, 5'd0, 16'h0040));
		emit(encR(`FN_ADDU, 5'd3, 5'd1, 5'd2));
		emit(encI(`OP_SW, 5'd3, 5'd0, 16'h0080));
		emit(encI(`OP_SW, 5'd1, 5'd0, 16'h0084));
		emit(encI(`OP_LW, 5'd4, 5'd0, 16'h0040));
		emit(encI(`OP_SW, 5'd4, 5'd0, 16'h0088));    // Load straight into store data
		finishProgram();
		expectStore(32'h80, v + signExt(k));
		expectStore(32'h84, v);
		expectStore(32'h88, v);
		runProgram();
		checkReg(5'd1, v);
		checkReg(5'd2, signExt(k));
		checkReg(5'd3, v + signExt(k));
		checkReg(5'd4, v);
	endtask

	// Operands made right before the branch with the fall-through store after it
	task automatic branchCase(input logic [5:0] op, input logic same, input logic [15:0] x,
			input logic [15:0] y, input logic [15:0] addr);
		logic taken;
		taken = (op == `OP_BEQ) == same;
		emit(encI(`OP_ADDIU, 5'd1, 5'd0, x));
		emit(encI(`OP_ADDIU, 5'd2, 5'd0, same ? x : y));
		emit(encI(op, 5'd2, 5'd1, 16'd1));
		emit(encI(`OP_SW, 5'd1, 5'd0, addr));
		if (!taken) begin
			expectStore({16'h0000, addr}, signExt(x));
		end
	endtask

	task automatic branchTest();
		logic [15:0] x;
		logic [15:0] y;
		word         v;
		x = 16'($urandom());
		y = x ^ {15'($urandom()), 1'b1};    // Always differs from x
		v = $urandom() | 32'd1;
		dataMem[16] = v;
		newProgram();
		branchCase(`OP_BEQ, 1'b1, x, y, 16'h0100);
		branchCase(`OP_BEQ, 1'b0, x, y, 16'h0104);
		branchCase(`OP_BNE, 1'b0, x, y, 16'h0108);
		branchCase(`OP_BNE, 1'b1, x, y, 16'h010C);
		// Compare waits on a load still in flight
		emit(encI(`OP_LW, 5'd5, 5'd0, 16'h0040));
		emit(encI(`OP_BNE, 5'd0, 5'd5, 16'd1));
		emit(encI(`OP_SW, 5'd5, 5'd0, 16'h0110));
		emit(encI(`OP_LW, 5'd6, 5'd0, 16'h0040));
		emit(encI(`OP_BEQ, 5'd0, 5'd6, 16'd1));
		emit(encI(`OP_SW, 5'd6, 5'd0, 16'h0114));
		expectStore(32'h114, v);
		finishProgram();
		runProgram();
	endtask

	task automatic loopTest();
		int  n;
		word loopPc;
		n = 1 + int'($urandom() % 20);
		newProgram();
		emit(encI(`OP_ADDIU, 5'd1, 5'd0, 16'(n)));
		emit(encI(`OP_ADDIU, 5'd2, 5'd0, 16'd0));
		loopPc = here();
		emit(encR(`FN_ADDU, 5'd2, 5'd2, 5'd1));
		emit(encI(`OP_ADDIU, 5'd1, 5'd1, 16'hFFFF));
		emit(encI(`OP_BEQ, 5'd0, 5'd1, 16'd1));
		emit(encJ(loopPc));
		emit(encI(`OP_SW, 5'd2, 5'd0, 16'h0200));
		finishProgram();
		expectStore(32'h200, word'(n * (n + 1) / 2));
		runProgram();
		checkReg(5'd2, word'(n * (n + 1) / 2));
		checkReg(5'd1, '0);
	endtask

	task automatic resetTest();
		logic [15:0] k;
		k = 16'($urandom());
		newProgram();
		emit(encI(`OP_ADDIU, 5'd1, 5'd0, k));
		emit(encI(`OP_SW, 5'd1, 5'd0, 16'h0300));
		emit(encI(`OP_ADDIU, 5'd2, 5'd0, 16'd30));
		emit(encI(`OP_ADDIU, 5'd2, 5'd2, 16'hFFFF));
		emit(encI(`OP_BNE, 5'd0, 5'd2, 16'hFFFE));    // Back one instruction
		finishProgram();
		expectStore(32'h300, signExt(k));
		expectStore(32'h300, signExt(k));    // Repeated after the second reset
		startRun();
		while (stAddr.size() < 1) @(negedge iCLK);
		holdReset();
		while (!doneSeen) @(negedge iCLK);
		checkStores();
	endtask

	initial begin
		void'($urandom(32'h6cc2));
		iRST      = 1'b1;
		regSelect = '0;
		doneSeen  = 1'b0;
		for (int i = 0; i < 256; i++) begin
			instrMem[i] = '0;
			dataMem[i]  = 32'hDA7A_0000 | word'(i * 4);
		end
		aluChainTest();
		loadUseTest();
		branchTest();
		loopTest();
		resetTest();
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== design/mipsPipeline.sv ====
module mipsPipeline (
	input  logic            iCLK,
	input  logic            iRST,
	output mipsPkg::word    instrAddr,
	input  mipsPkg::word    instrData,
	output mipsPkg::dataBus dBus,
	input  mipsPkg::word    dataRead,
	input  mipsPkg::regIdx  regSelect,
	output mipsPkg::word    regValue
);
	import mipsPkg::*;

	// Pipeline registers
	ifIdReg  ifId;
	idExReg  idEx;
	exMemReg exMem;
	memWbReg memWb;

	logic  stall;
	logic  redirect;
	logic  branchUse;
	word   target;
	fwdSel fwdA;
	fwdSel fwdB;
	fwdSel fwdBranchA;
	fwdSel fwdBranchB;

	fetchStage i_fetchStage (
		.iCLK      (iCLK),
		.iRST      (iRST),
		.stall     (stall),
		.redirect  (redirect),
		.target    (target),
		.instrData (instrData),
		.pc        (instrAddr),
		.ifId      (ifId)
	);

	decodeStage i_decodeStage (
		.iCLK       (iCLK),
		.iRST       (iRST),
		.ifId       (ifId),
		.memWb      (memWb),
		.exMemAlu   (exMem.aluResult),
		.fwdBranchA (fwdBranchA),
		.fwdBranchB (fwdBranchB),
		.stall      (stall),
		.redirect   (redirect),
		.target     (target),
		.branchUse  (branchUse),
		.idEx       (idEx),
		.regSelect  (regSelect),
		.regValue   (regValue)
	);

	executeStage i_executeStage (
		.iCLK   (iCLK),
		.iRST   (iRST),
		.idEx   (idEx),
		.fwdA   (fwdA),
		.fwdB   (fwdB),
		.memAlu (exMem.aluResult),
		.wbData (memWb.writeData),
		.exMem  (exMem)
	);

	memoryStage i_memoryStage (
		.iCLK     (iCLK),
		.iRST     (iRST),
		.exMem    (exMem),
		.dataRead (dataRead),
		.dBus     (dBus),
		.memWb    (memWb)
	);

	hazardUnit i_hazardUnit (
		.ifId       (ifId),
		.idEx       (idEx),
		.exMem      (exMem),
		.memWb      (memWb),
		.branchUse  (branchUse),
		.stall      (stall),
		.fwdA       (fwdA),
		.fwdB       (fwdB),
		.fwdBranchA (fwdBranchA),
		.fwdBranchB (fwdBranchB)
	);

endmodule

// ==== design/hazardUnit.sv ====
`include "mips_settings.svh"

module hazardUnit (
	input  mipsPkg::ifIdReg  ifId,
	input  mipsPkg::idExReg  idEx,
	input  mipsPkg::exMemReg exMem,
	input  mipsPkg::memWbReg memWb,
	input  logic             branchUse,
	output logic             stall,
	output mipsPkg::fwdSel   fwdA,
	output mipsPkg::fwdSel   fwdB,
	output mipsPkg::fwdSel   fwdBranchA,
	output mipsPkg::fwdSel   fwdBranchB
);
	import mipsPkg::*;

	regIdx idRs;
	regIdx idRt;
	regIdx exDest;
	logic  loadUse;
	logic  branchWait;

	// Newest producer wins
	function automatic fwdSel pickFwd(input regIdx src);
		if (src != '0 && exMem.regWrite && exMem.dest == src) begin
			return `FWD_MEM;
		end else if (src != '0 && memWb.regWrite && memWb.dest == src) begin
			return `FWD_WB;
		end
		return `FWD_REG;
	endfunction

	function automatic logic needs(input regIdx dst);
		return dst != '0 && (dst == idRs || dst == idRt);
	endfunction

	assign idRs   = ifId.instr[25:21];
	assign idRt   = ifId.instr[20:16];
	assign exDest = idEx.ctrl.dstRd ? idEx.instr[15:11] : idEx.instr[20:16];

	always_comb begin
		loadUse    = idEx.ctrl.memRead && needs(exDest);
		// Compare in decode needs values not yet produced
		branchWait = branchUse && ((idEx.ctrl.regWrite && needs(exDest))
			|| (exMem.memRead && needs(exMem.dest)));
		stall      = loadUse | branchWait;

		fwdA = pickFwd(idEx.instr[25:21]);
		fwdB = pickFwd(idEx.instr[20:16]);

		// Only the MEM-stage ALU result reaches the compare
		fwdBranchA = (idRs != '0 && exMem.regWrite && !exMem.memRead && exMem.dest == idRs)
			? `FWD_MEM : `FWD_REG;
		fwdBranchB = (idRt != '0 && exMem.regWrite && !exMem.memRead && exMem.dest == idRt)
			? `FWD_MEM : `FWD_REG;
	end

endmodule

// ==== design/memoryStage.sv ====
module memoryStage (
	input  logic             iCLK,
	input  logic             iRST,
	input  mipsPkg::exMemReg exMem,
	input  mipsPkg::word     dataRead,
	output mipsPkg::dataBus  dBus,
	output mipsPkg::memWbReg memWb
);
	import mipsPkg::*;

	word result;

	// Strobes straight from EX/MEM, low while in reset
	assign dBus.address   = exMem.aluResult;
	assign dBus.writeData = exMem.storeData;
	assign dBus.read      = exMem.memRead;
	assign dBus.write     = exMem.memWrite;

	assign result = exMem.memRead ? dataRead : exMem.aluResult;

	always_ff @(posedge iCLK or posedge iRST) begin
		if (iRST) begin
			memWb <= '0;
		end else begin
			memWb <= '{writeData: result, dest: exMem.dest, regWrite: exMem.regWrite};
		end
	end

endmodule

// ==== design/executeStage.sv ====
`include "mips_settings.svh"

module executeStage (
	input  logic             iCLK,
	input  logic             iRST,
	input  mipsPkg::idExReg  idEx,
	input  mipsPkg::fwdSel   fwdA,
	input  mipsPkg::fwdSel   fwdB,
	input  mipsPkg::word     memAlu,
	input  mipsPkg::word     wbData,
	output mipsPkg::exMemReg exMem
);
	import mipsPkg::*;

	word   opA;
	word   regB;    // Forwarded rt, also the store data
	word   opB;
	word   immExt;
	word   aluOut;
	regIdx dest;

	function automatic word fwdMux(input fwdSel sel, input word regVal,
			input word memVal, input word wbVal);
		case (sel)
			`FWD_MEM: return memVal;
			`FWD_WB:  return wbVal;
			default:  return regVal;
		endcase
	endfunction

	always_comb begin
		opA  = fwdMux(fwdA, idEx.readA, memAlu, wbData);
		regB = fwdMux(fwdB, idEx.readB, memAlu, wbData);
		case (idEx.ctrl.immSrc)
			`IMM_ZERO:  immExt = {16'h0000, idEx.instr[15:0]};
			`IMM_UPPER: immExt = {idEx.instr[15:0], 16'h0000};
			default:    immExt = {{16{idEx.instr[15]}}, idEx.instr[15:0]};
		endcase
		opB = idEx.ctrl.useImm ? immExt : regB;
	end

	always_comb begin
		case (idEx.ctrl.aluCtl)
			`ALU_ADD: aluOut = opA + opB;
			`ALU_SUB: aluOut = opA - opB;
			`ALU_AND: aluOut = opA & opB;
			`ALU_OR:  aluOut = opA | opB;
			`ALU_SLT: aluOut = {{(`WORD_WIDTH-1){1'b0}}, $signed(opA) < $signed(opB)};
			`ALU_LUI: aluOut = opB;    // Already moved to the upper half
			default:  aluOut = '0;
		endcase
	end

	assign dest = idEx.ctrl.dstRd ? idEx.instr[15:11] : idEx.instr[20:16];

	always_ff @(posedge iCLK or posedge iRST) begin
		if (iRST) begin
			exMem <= '0;
		end else begin
			exMem.aluResult <= aluOut;
			exMem.storeData <= regB;
			exMem.dest      <= dest;
			exMem.regWrite  <= idEx.ctrl.regWrite;
			exMem.memRead   <= idEx.ctrl.memRead;
			exMem.memWrite  <= idEx.ctrl.memWrite;
		end
	end

endmodule

// ==== design/decodeStage.sv ====
`include "mips_settings.svh"

module decodeStage (
	input  logic             iCLK,
	input  logic             iRST,
	input  mipsPkg::ifIdReg  ifId,
	input  mipsPkg::memWbReg memWb,
	input  mipsPkg::word     exMemAlu,
	input  mipsPkg::fwdSel   fwdBranchA,
	input  mipsPkg::fwdSel   fwdBranchB,
	input  logic             stall,
	output logic             redirect,
	output mipsPkg::word     target,
	output logic             branchUse,
	output mipsPkg::idExReg  idEx,
	input  mipsPkg::regIdx   regSelect,
	output mipsPkg::word     regValue
);
	import mipsPkg::*;

	word       readA;
	word       readB;
	word       cmpA;
	word       cmpB;
	word       branchTarget;
	word       jumpTarget;
	ctrlBundle ctrl;
	logic      branchEq;
	logic      branchNe;
	logic      jump;
	logic      equal;

	registerFile i_registerFile (
		.iCLK        (iCLK),
		.iRST        (iRST),
		.readAddrA   (ifId.instr[25:21]),    // rs
		.readAddrB   (ifId.instr[20:16]),    // rt
		.writeAddr   (memWb.dest),
		.writeData   (memWb.writeData),
		.writeEnable (memWb.regWrite),
		.readA       (readA),
		.readB       (readB),
		.dispSelect  (regSelect),
		.dispValue   (regValue)
	);

	controlUnit i_controlUnit (
		.opcode   (ifId.instr[31:26]),
		.funct    (ifId.instr[5:0]),
		.ctrl     (ctrl),
		.branchEq (branchEq),
		.branchNe (branchNe),
		.jump     (jump)
	);

	// Early compare, MEM result bypassed in
	assign cmpA  = (fwdBranchA == `FWD_MEM) ? exMemAlu : readA;
	assign cmpB  = (fwdBranchB == `FWD_MEM) ? exMemAlu : readB;
	assign equal = (cmpA == cmpB);

	assign branchTarget = ifId.pc4 + {{14{ifId.instr[15]}}, ifId.instr[15:0], 2'b00};
	assign jumpTarget   = {ifId.pc4[31:28], ifId.instr[25:0], 2'b00};

	assign branchUse = branchEq | branchNe;
	assign redirect  = jump | (branchEq & equal) | (branchNe & ~equal);
	assign target    = jump ? jumpTarget : branchTarget;

	always_ff @(posedge iCLK or posedge iRST) begin
		if (iRST) begin
			idEx <= '0;
		end else if (stall) begin
			idEx <= '0;    // Bubble
		end else begin
			idEx <= '{instr: ifId.instr, readA: readA, readB: readB, ctrl: ctrl};
		end
	end

endmodule

// ==== design/fetchStage.sv ====
`include "mips_settings.svh"

module fetchStage (
	input  logic            iCLK,
	input  logic            iRST,
	input  logic            stall,
	input  logic            redirect,
	input  mipsPkg::word    target,
	input  mipsPkg::word    instrData,
	output mipsPkg::word    pc,
	output mipsPkg::ifIdReg ifId
);
	import mipsPkg::*;

	word pc4;

	assign pc4 = pc + `WORD_WIDTH'd4;

	always_ff @(posedge iCLK or posedge iRST) begin
		if (iRST) begin
			pc   <= `RESET_PC;
			ifId <= '0;
		end else if (!stall) begin    // Stall holds PC and IF/ID
			pc <= redirect ? target : pc4;
			if (redirect) begin
				ifId <= '0;    // Squash the wrong-path fetch
			end else begin
				ifId <= '{pc4: pc4, instr: instrData};
			end
		end
	end

endmodule

// ==== design/controlUnit.sv ====
`include "mips_settings.svh"

module controlUnit (
	input  logic [5:0]         opcode,
	input  logic [5:0]         funct,
	output mipsPkg::ctrlBundle ctrl,
	output logic               branchEq,
	output logic               branchNe,
	output logic               jump
);

	always_comb begin
		ctrl     = '0;    // Unknown codes decode as nop
		branchEq = 1'b0;
		branchNe = 1'b0;
		jump     = 1'b0;
		case (opcode)
			`OP_RTYPE: begin
				ctrl.dstRd    = 1'b1;
				ctrl.regWrite = 1'b1;
				case (funct)
					`FN_ADDU: ctrl.aluCtl = `ALU_ADD;
					`FN_SUBU: ctrl.aluCtl = `ALU_SUB;
					`FN_AND:  ctrl.aluCtl = `ALU_AND;
					`FN_OR:   ctrl.aluCtl = `ALU_OR;
					`FN_SLT:  ctrl.aluCtl = `ALU_SLT;
					default:  ctrl        = '0;
				endcase
			end
			`OP_ADDIU: ctrl = '{`ALU_ADD, `IMM_SIGN, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0};
			`OP_ANDI:  ctrl = '{`ALU_AND, `IMM_ZERO, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0};
			`OP_ORI:   ctrl = '{`ALU_OR, `IMM_ZERO, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0};
			`OP_LUI:   ctrl = '{`ALU_LUI, `IMM_UPPER, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0};
			// Address is base plus signed offset
			`OP_LW:    ctrl = '{`ALU_ADD, `IMM_SIGN, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0};
			`OP_SW:    ctrl = '{`ALU_ADD, `IMM_SIGN, 1'b1, 1'b0, 1'b0, 1'b0, 1'b1};
			`OP_BEQ:   branchEq = 1'b1;
			`OP_BNE:   branchNe = 1'b1;
			`OP_J:     jump     = 1'b1;
			default:   ctrl     = '0;
		endcase
	end

endmodule

// ==== design/registerFile.sv ====
`include "mips_settings.svh"

module registerFile (
	input  logic           iCLK,
	input  logic           iRST,
	input  mipsPkg::regIdx readAddrA,
	input  mipsPkg::regIdx readAddrB,
	input  mipsPkg::regIdx writeAddr,
	input  mipsPkg::word   writeData,
	input  logic           writeEnable,
	output mipsPkg::word   readA,
	output mipsPkg::word   readB,
	input  mipsPkg::regIdx dispSelect,
	output mipsPkg::word   dispValue
);
	import mipsPkg::*;

	localparam int NumRegs = 2 ** `REG_ADDR_WIDTH;

	word regs [NumRegs];

	// $zero first, then same-cycle write bypass
	function automatic word readPort(input regIdx addr);
		if (addr == '0) begin
			return '0;
		end else if (writeEnable && writeAddr == addr) begin
			return writeData;
		end
		return regs[addr];
	endfunction

	always_ff @(posedge iCLK or posedge iRST) begin
		if (iRST) begin
			for (int i = 0; i < NumRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	always_comb begin
		readA = readPort(readAddrA);
		readB = readPort(readAddrB);
	end

	assign dispValue = regs[dispSelect];    // Register 0 never written

endmodule

// ==== design/mipsPkg.sv ====
`include "mips_settings.svh"

package mipsPkg;

	typedef logic [`WORD_WIDTH-1:0]     word;
	typedef logic [`REG_ADDR_WIDTH-1:0] regIdx;
	typedef logic [2:0]                 aluOp;
	typedef logic [1:0]                 fwdSel;    // Register file, MEM or WB

	// Decoded control, travels with the instruction into execute
	typedef struct packed {
		aluOp       aluCtl;
		logic [1:0] immSrc;    // Sign, zero or upper
		logic       useImm;
		logic       dstRd;     // Destination is rd, else rt
		logic       regWrite;
		logic       memRead;
		logic       memWrite;
	} ctrlBundle;

	typedef struct packed {
		word pc4;
		word instr;
	} ifIdReg;

	typedef struct packed {
		word       instr;
		word       readA;
		word       readB;
		ctrlBundle ctrl;
	} idExReg;

	typedef struct packed {
		word   aluResult;
		word   storeData;
		regIdx dest;
		logic  regWrite;
		logic  memRead;
		logic  memWrite;
	} exMemReg;

	typedef struct packed {
		word   writeData;
		regIdx dest;
		logic  regWrite;
	} memWbReg;

	// Data memory port
	typedef struct packed {
		word  address;
		word  writeData;
		logic read;
		logic write;
	} dataBus;

endpackage

// ==== design/mips_settings.svh ====
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Datapath
`define WORD_WIDTH      32
`define REG_ADDR_WIDTH  5
`define RESET_PC        32'h0000_0000

// Primary opcodes
`define OP_RTYPE  6'h00
`define OP_J      6'h02
`define OP_BEQ    6'h04
`define OP_BNE    6'h05
`define OP_ADDIU  6'h09
`define OP_ANDI   6'h0C
`define OP_ORI    6'h0D
`define OP_LUI    6'h0F
`define OP_LW     6'h23
`define OP_SW     6'h2B

// R-type funct field
`define FN_ADDU   6'h21
`define FN_SUBU   6'h23
`define FN_AND    6'h24
`define FN_OR     6'h25
`define FN_SLT    6'h2A

// ALU operations
`define ALU_ADD   3'd0
`define ALU_SUB   3'd1
`define ALU_AND   3'd2
`define ALU_OR    3'd3
`define ALU_SLT   3'd4
`define ALU_LUI   3'd5

// Immediate extension modes
`define IMM_SIGN  2'd0
`define IMM_ZERO  2'd1
`define IMM_UPPER 2'd2

// Forwarding sources
`define FWD_REG   2'd0
`define FWD_MEM   2'd1
`define FWD_WB    2'd2

`endif
